/* hw/ttc_pkg.sv */
package ttc_pkg;

   // ---------------------------------------------------------------------
   // Sizes
   // ---------------------------------------------------------------------
   localparam int NUM_CH      = 3;    // Timer channels
   localparam int CNT_W       = 16;   // Counter, interval and match width
   localparam int CLK_CTRL_W  = 5;
   localparam int CNTR_CTRL_W = 5;
   localparam int INT_W       = 5;    // Interrupt latch and enable width

   // Clock control fields
   localparam int CLK_PS_EN   = 0;    // Prescale enable
   localparam int CLK_EXP_LSB = 1;    // Exponent N in bits 4:1

   // Counter control bits
   localparam int CC_DIS   = 0;
   localparam int CC_INTV  = 1;
   localparam int CC_DEC   = 2;
   localparam int CC_MATCH = 3;
   localparam int CC_RST   = 4;       // Self clearing

   localparam logic [CNTR_CTRL_W-1:0] CNTR_CTRL_RST = 5'b00001;   // Stopped

   // Interrupt bits
   localparam int IRQ_INTV = 0;
   localparam int IRQ_M1   = 1;
   localparam int IRQ_M2   = 2;
   localparam int IRQ_M3   = 3;
   localparam int IRQ_OVF  = 4;

   // ---------------------------------------------------------------------
   // Register bases, channel n at base + 4n
   // ---------------------------------------------------------------------
   localparam logic [7:0] OFS_CLK  = 8'h00;
   localparam logic [7:0] OFS_CNTR = 8'h0C;
   localparam logic [7:0] OFS_VAL  = 8'h18;   // Read only
   localparam logic [7:0] OFS_INTV = 8'h24;
   localparam logic [7:0] OFS_M1   = 8'h30;
   localparam logic [7:0] OFS_M2   = 8'h3C;
   localparam logic [7:0] OFS_M3   = 8'h48;
   localparam logic [7:0] OFS_IRQ  = 8'h54;   // Clear on read
   localparam logic [7:0] OFS_IEN  = 8'h60;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_LOAD = 2'd1,
      ST_RUN  = 2'd2
   } cnt_state_t;

endpackage

/* hw/ttc_prescaler.sv */
module ttc_prescaler (
   input  logic                            pclk,
   input  logic                            arst_n,
   input  logic                            run,        // FSM in run state
   input  logic                            restart,    // Load cycle
   input  logic [ttc_pkg::CLK_CTRL_W-1:0]  clk_ctrl,
   output logic                            tick
);
   import ttc_pkg::*;

   logic [16:0] cyc;        // Cycles into current period
   logic [16:0] period;     // 2^(N+1) up to 65536
   logic        last;

   // Period 1 when prescaling is off
   assign period = clk_ctrl[CLK_PS_EN] ?
                   (17'd1 << ({1'b0, clk_ctrl[CLK_CTRL_W-1:CLK_EXP_LSB]} + 5'd1)) : 17'd1;
   assign last   = (cyc == period - 17'd1);
   assign tick   = run & last;

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         cyc <= '0;
      end else if (restart) begin
         cyc <= '0;
      end else if (run) begin
         if (last) begin
            cyc <= '0;                // Wrap with the tick
         end else begin
            cyc <= cyc + 17'd1;
         end
      end
   end

endmodule

/* hw/ttc_count_fsm.sv */
module ttc_count_fsm (
   input  logic                             pclk,
   input  logic                             arst_n,
   input  logic                             cntr_sel,     // Control write this cycle
   input  logic [ttc_pkg::CNTR_CTRL_W-1:0]  wdata_ctrl,   // Value being written
   input  logic                             dis,          // Stored disable bit
   output ttc_pkg::cnt_state_t              state,
   output logic                             load
);
   import ttc_pkg::*;

   cnt_state_t state_nxt;
   logic       stop_req;
   logic       start_req;

   // Stop wins over restart in the same write
   assign stop_req  = cntr_sel & wdata_ctrl[CC_DIS];
   assign start_req = cntr_sel & ~wdata_ctrl[CC_DIS] & (dis | wdata_ctrl[CC_RST]);

   always_comb begin
      state_nxt = state;
      if (stop_req) begin
         state_nxt = ST_IDLE;
      end else if (start_req) begin
         state_nxt = ST_LOAD;
      end else begin
         case (state)
            ST_IDLE: state_nxt = ST_IDLE;
            ST_LOAD: state_nxt = ST_RUN;      // Single load cycle
            ST_RUN:  state_nxt = ST_RUN;
            default: state_nxt = ST_IDLE;     // Unused code
         endcase
      end
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign load = (state == ST_LOAD);

endmodule

/* hw/ttc_counter.sv */
module ttc_counter (
   input  logic                        pclk,
   input  logic                        arst_n,
   input  logic                        load,        // Load start value
   input  logic                        tick,        // Step enable
   input  logic                        dec,
   input  logic                        intv_mode,
   input  logic                        match_en,
   input  logic [ttc_pkg::CNT_W-1:0]   interval,
   input  logic [ttc_pkg::CNT_W-1:0]   match1,
   input  logic [ttc_pkg::CNT_W-1:0]   match2,
   input  logic [ttc_pkg::CNT_W-1:0]   match3,
   output logic [ttc_pkg::CNT_W-1:0]   count,
   output logic [ttc_pkg::INT_W-1:0]   events       // One cycle pulses
);
   import ttc_pkg::*;

   logic [CNT_W-1:0] start;
   logic [CNT_W-1:0] nxt;
   logic             wrap_intv;
   logic             wrap_ovf;

   assign start = (dec && intv_mode) ? interval : '0;

   // Next count and wrap detection
   always_comb begin
      wrap_intv = 1'b0;
      wrap_ovf  = 1'b0;
      if (!dec) begin
         nxt = count + CNT_W'(1);
         if (intv_mode && count >= interval) begin
            nxt       = '0;
            wrap_intv = 1'b1;
         end else if (!intv_mode && count == '1) begin
            wrap_ovf  = 1'b1;                       // Rolls to 0 by itself
         end
      end else begin
         nxt       = (intv_mode && count == '0) ? interval : count - CNT_W'(1);
         wrap_intv = intv_mode & (count == '0);     // Reload
         wrap_ovf  = ~intv_mode & (count == '0);    // Under to 0xFFFF
      end
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         count  <= '0;
         events <= '0;
      end else begin
         events <= '0;
         if (load) begin
            count <= start;
         end else if (tick) begin
            count            <= nxt;
            events[IRQ_INTV] <= wrap_intv;
            events[IRQ_OVF]  <= wrap_ovf;
            events[IRQ_M1]   <= match_en & (nxt == match1);
            events[IRQ_M2]   <= match_en & (nxt == match2);
            events[IRQ_M3]   <= match_en & (nxt == match3);
         end
      end
   end

endmodule

/* hw/ttc_channel.sv */
module ttc_channel (
   input  logic                             pclk,
   input  logic                             arst_n,
   input  logic [15:0]                      pwdata,
   input  logic                             clk_sel,
   input  logic                             cntr_sel,
   input  logic                             intv_sel,
   input  logic                             m1_sel,
   input  logic                             m2_sel,
   input  logic                             m3_sel,
   input  logic                             ien_sel,
   input  logic                             irq_clr,     // Interrupt register read
   output logic [ttc_pkg::CLK_CTRL_W-1:0]   clk_ctrl,
   output logic [ttc_pkg::CNTR_CTRL_W-1:0]  cntr_ctrl,
   output logic [ttc_pkg::CNT_W-1:0]        counter_val,
   output logic [ttc_pkg::CNT_W-1:0]        interval,
   output logic [ttc_pkg::CNT_W-1:0]        match1,
   output logic [ttc_pkg::CNT_W-1:0]        match2,
   output logic [ttc_pkg::CNT_W-1:0]        match3,
   output logic [ttc_pkg::INT_W-1:0]        irq_reg,
   output logic [ttc_pkg::INT_W-1:0]        irq_en,
   output logic                             interrupt
);
   import ttc_pkg::*;

   cnt_state_t       state;
   logic             load;
   logic             run;
   logic             tick;
   logic [INT_W-1:0] events;

   assign run = (state == ST_RUN);

   // ---------------------------------------------------------------------
   // Software registers
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= CNTR_CTRL_RST;
         interval  <= '0;
         match1    <= '0;
         match2    <= '0;
         match3    <= '0;
         irq_en    <= '0;
      end else begin
         if (clk_sel)  clk_ctrl <= pwdata[CLK_CTRL_W-1:0];
         if (cntr_sel) begin
            cntr_ctrl         <= pwdata[CNTR_CTRL_W-1:0];
            cntr_ctrl[CC_RST] <= 1'b0;                  // Strobe only
         end
         if (intv_sel) interval <= pwdata[CNT_W-1:0];
         if (m1_sel)   match1   <= pwdata[CNT_W-1:0];
         if (m2_sel)   match2   <= pwdata[CNT_W-1:0];
         if (m3_sel)   match3   <= pwdata[CNT_W-1:0];
         if (ien_sel)  irq_en   <= pwdata[INT_W-1:0];
      end
   end

   // Sticky latch, new events beat the read clear
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         irq_reg   <= '0;
         interrupt <= 1'b0;
      end else begin
         irq_reg   <= (irq_clr ? '0 : irq_reg) | events;
         interrupt <= |(irq_reg & irq_en);
      end
   end

   // ---------------------------------------------------------------------
   // Timing path
   // ---------------------------------------------------------------------
   ttc_count_fsm i_fsm (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .cntr_sel   (cntr_sel),
      .wdata_ctrl (pwdata[CNTR_CTRL_W-1:0]),
      .dis        (cntr_ctrl[CC_DIS]),
      .state      (state),
      .load       (load)
   );

   ttc_prescaler i_prescaler (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .run      (run),
      .restart  (load),          // Period restarts with each load
      .clk_ctrl (clk_ctrl),
      .tick     (tick)
   );

   ttc_counter i_counter (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .load      (load),
      .tick      (tick),
      .dec       (cntr_ctrl[CC_DEC]),
      .intv_mode (cntr_ctrl[CC_INTV]),
      .match_en  (cntr_ctrl[CC_MATCH]),
      .interval  (interval),
      .match1    (match1),
      .match2    (match2),
      .match3    (match3),
      .count     (counter_val),
      .events    (events)
   );

endmodule

/* hw/ttc_apb_regs.sv */
module ttc_apb_regs (
   input  logic                               pclk,
   input  logic                               arst_n,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [7:0]                         paddr,
   input  logic [ttc_pkg::CLK_CTRL_W-1:0]     clk_ctrl    [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNTR_CTRL_W-1:0]    cntr_ctrl   [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNT_W-1:0]          counter_val [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNT_W-1:0]          interval    [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNT_W-1:0]          match1      [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNT_W-1:0]          match2      [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::CNT_W-1:0]          match3      [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::INT_W-1:0]          irq_reg     [ttc_pkg::NUM_CH],
   input  logic [ttc_pkg::INT_W-1:0]          irq_en      [ttc_pkg::NUM_CH],
   output logic [31:0]                        prdata,
   output logic [ttc_pkg::NUM_CH-1:0]         clk_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         cntr_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         intv_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         m1_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         m2_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         m3_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         ien_sel,
   output logic [ttc_pkg::NUM_CH-1:0]         irq_clr
);
   import ttc_pkg::*;

   logic setup_q;      // Last cycle was a setup phase
   logic access;       // Valid access cycle
   logic wr_acc;
   logic rd_acc;

   // Register kind base plus channel slot
   function automatic logic hit(input logic [7:0] addr, input logic [7:0] ofs, input int ch);
      return addr == 8'(ofs + 4 * ch);
   endfunction

   // ---------------------------------------------------------------------
   // Phase tracking
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel & ~penable;
      end
   end

   assign access = psel & penable & setup_q;   // Only after a real setup
   assign wr_acc = access & pwrite;
   assign rd_acc = access & ~pwrite;

   // Write strobes and clear on read, one bit per channel
   always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
         clk_sel[c]  = wr_acc & hit(paddr, OFS_CLK, c);
         cntr_sel[c] = wr_acc & hit(paddr, OFS_CNTR, c);
         intv_sel[c] = wr_acc & hit(paddr, OFS_INTV, c);
         m1_sel[c]   = wr_acc & hit(paddr, OFS_M1, c);
         m2_sel[c]   = wr_acc & hit(paddr, OFS_M2, c);
         m3_sel[c]   = wr_acc & hit(paddr, OFS_M3, c);
         ien_sel[c]  = wr_acc & hit(paddr, OFS_IEN, c);
         irq_clr[c]  = rd_acc & hit(paddr, OFS_IRQ, c);   // Latch clears at this edge
      end
   end

   // ---------------------------------------------------------------------
   // Read mux, zero extended
   // ---------------------------------------------------------------------
   always_comb begin
      prdata = '0;                                 // Idle and unmapped
      if (rd_acc) begin
         for (int c = 0; c < NUM_CH; c++) begin
            if (hit(paddr, OFS_CLK, c))  prdata = 32'(clk_ctrl[c]);
            if (hit(paddr, OFS_CNTR, c)) prdata = 32'(cntr_ctrl[c]);
            if (hit(paddr, OFS_VAL, c))  prdata = 32'(counter_val[c]);
            if (hit(paddr, OFS_INTV, c)) prdata = 32'(interval[c]);
            if (hit(paddr, OFS_M1, c))   prdata = 32'(match1[c]);
            if (hit(paddr, OFS_M2, c))   prdata = 32'(match2[c]);
            if (hit(paddr, OFS_M3, c))   prdata = 32'(match3[c]);
            if (hit(paddr, OFS_IRQ, c))  prdata = 32'(irq_reg[c]);
            if (hit(paddr, OFS_IEN, c))  prdata = 32'(irq_en[c]);
         end
      end
   end

endmodule

/* hw/ttc_lite.sv */
module ttc_lite (
   input  logic                        pclk,
   input  logic                        arst_n,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [7:0]                  paddr,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic [ttc_pkg::NUM_CH-1:0]  interrupt     // One line per channel
);
   import ttc_pkg::*;

   // Per channel register views
   logic [CLK_CTRL_W-1:0]  clk_ctrl    [NUM_CH];
   logic [CNTR_CTRL_W-1:0] cntr_ctrl   [NUM_CH];
   logic [CNT_W-1:0]       counter_val [NUM_CH];
   logic [CNT_W-1:0]       interval    [NUM_CH];
   logic [CNT_W-1:0]       match1      [NUM_CH];
   logic [CNT_W-1:0]       match2      [NUM_CH];
   logic [CNT_W-1:0]       match3      [NUM_CH];
   logic [INT_W-1:0]       irq_reg     [NUM_CH];
   logic [INT_W-1:0]       irq_en      [NUM_CH];

   // Strobes, bit n for channel n
   logic [NUM_CH-1:0] clk_sel, cntr_sel, intv_sel;
   logic [NUM_CH-1:0] m1_sel, m2_sel, m3_sel;
   logic [NUM_CH-1:0] ien_sel, irq_clr;

   ttc_apb_regs i_regs (
      .pclk        (pclk),
      .arst_n      (arst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .clk_ctrl    (clk_ctrl),
      .cntr_ctrl   (cntr_ctrl),
      .counter_val (counter_val),
      .interval    (interval),
      .match1      (match1),
      .match2      (match2),
      .match3      (match3),
      .irq_reg     (irq_reg),
      .irq_en      (irq_en),
      .prdata      (prdata),
      .clk_sel     (clk_sel),
      .cntr_sel    (cntr_sel),
      .intv_sel    (intv_sel),
      .m1_sel      (m1_sel),
      .m2_sel      (m2_sel),
      .m3_sel      (m3_sel),
      .ien_sel     (ien_sel),
      .irq_clr     (irq_clr)
   );

   for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
      ttc_channel i_channel (
         .pclk        (pclk),
         .arst_n      (arst_n),
         .pwdata      (pwdata[15:0]),     // Registers are 16 bits or less
         .clk_sel     (clk_sel[g]),
         .cntr_sel    (cntr_sel[g]),
         .intv_sel    (intv_sel[g]),
         .m1_sel      (m1_sel[g]),
         .m2_sel      (m2_sel[g]),
         .m3_sel      (m3_sel[g]),
         .ien_sel     (ien_sel[g]),
         .irq_clr     (irq_clr[g]),
         .clk_ctrl    (clk_ctrl[g]),
         .cntr_ctrl   (cntr_ctrl[g]),
         .counter_val (counter_val[g]),
         .interval    (interval[g]),
         .match1      (match1[g]),
         .match2      (match2[g]),
         .match3      (match3[g]),
         .irq_reg     (irq_reg[g]),
         .irq_en      (irq_en[g]),
         .interrupt   (interrupt[g])
      );
   end

endmodule

/* tb/ttc_lite_tb.sv */
module ttc_lite_tb;
   import ttc_pkg::*;

   localparam int PERIOD    = 4;
   localparam int RST_CYC   = 8;
   localparam int TBL_LEN   = 51;    // 27 reset rows, 21 readback rows, 3 unmapped
   localparam int ACC_GAP   = 2;     // Run cycles added by the start and stop accesses
   localparam int WAIT_CYC  = 600;   // Directed accesses plus counting waits
   localparam int TIMEOUT_CYC = TBL_LEN * 8 + WAIT_CYC + RST_CYC;

   localparam logic [7:0] ALL_OFS [9] = '{OFS_CLK, OFS_CNTR, OFS_VAL, OFS_INTV,
                                          OFS_M1, OFS_M2, OFS_M3, OFS_IRQ, OFS_IEN};

   logic              pclk;
   logic              arst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [7:0]        paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic [NUM_CH-1:0] interrupt;

   int          errors;
   logic [31:0] lfsr;

   // Stimulus table with one register access per row
   logic        tbl_wr    [TBL_LEN];
   logic [7:0]  tbl_addr  [TBL_LEN];
   logic [31:0] tbl_wdata [TBL_LEN];
   logic [31:0] tbl_exp   [TBL_LEN];
   logic [31:0] tbl_mask  [TBL_LEN];   // Bits outside read as 0

   ttc_lite DUT (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   initial pclk = 1'b0;
   always #(PERIOD / 2) pclk = ~pclk;

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------
   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return r;
   endfunction

   function automatic logic [7:0] reg_addr(input logic [7:0] ofs, input int ch);
      return ofs + 8'(4 * ch);
   endfunction

   // Readable bits of each writable register
   function automatic logic [31:0] width_mask(input logic [7:0] ofs);
      case (ofs)
         OFS_CLK:  return (32'd1 << CLK_CTRL_W) - 32'd1;
         OFS_CNTR: return ((32'd1 << CNTR_CTRL_W) - 32'd1) & ~(32'd1 << CC_RST);
         OFS_IEN:  return (32'd1 << INT_W) - 32'd1;
         default:  return (32'd1 << CNT_W) - 32'd1;
      endcase
   endfunction

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge pclk);
      psel    = 1'b1;                  // Setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;                  // Access phase captured at next rising edge
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;
      #1 data = prdata;                // Mid low phase well before the edge
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_irq(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp,
                            input string what);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Reset rows, random readback rows, unmapped rows
   task automatic build_table();
      int n;
      n = 0;
      for (int k = 0; k < 9; k++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            tbl_wr[n]    = 1'b0;
            tbl_addr[n]  = reg_addr(ALL_OFS[k], c);
            tbl_wdata[n] = '0;
            tbl_exp[n]   = (ALL_OFS[k] == OFS_CNTR) ? 32'(1 << CC_DIS) : 32'h0;
            tbl_mask[n]  = '1;
            n++;
         end
      end
      for (int k = 0; k < 9; k++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            if (ALL_OFS[k] != OFS_VAL && ALL_OFS[k] != OFS_IRQ) begin
               tbl_wr[n]    = 1'b1;
               tbl_addr[n]  = reg_addr(ALL_OFS[k], c);
               tbl_wdata[n] = lfsr_bits(32);
               if (ALL_OFS[k] == OFS_CNTR) tbl_wdata[n][CC_RST] = 1'b1;   // Restart strobe
               tbl_exp[n]   = tbl_wdata[n];
               tbl_mask[n]  = width_mask(ALL_OFS[k]);
               n++;
            end
         end
      end
      for (int u = 0; u < 3; u++) begin
         tbl_wr[n]    = 1'b1;
         tbl_addr[n]  = (u == 0) ? 8'h6C : ((u == 1) ? 8'h9A : 8'hFC);
         tbl_wdata[n] = lfsr_bits(32);
         tbl_exp[n]   = tbl_wdata[n];
         tbl_mask[n]  = '0;             // Nothing mapped here
         n++;
      end
   endtask

   // Up count in overflow mode stopped after k idle cycles
   task automatic count_case(input int ch, input logic [4:0] clk_val, input int k);
      logic [31:0] got;
      int          p;
      int          r;
      p = clk_val[0] ? (1 << (int'(clk_val[4:1]) + 1)) : 1;
      r = k + ACC_GAP;
      apb_write(reg_addr(OFS_CLK, ch), 32'(clk_val));
      apb_write(reg_addr(OFS_CNTR, ch), 32'h0);
      repeat (k) @(negedge pclk);
      apb_write(reg_addr(OFS_CNTR, ch), 32'(1 << CC_DIS));
      apb_read(reg_addr(OFS_VAL, ch), got);
      check_reg(got, 32'(r / p), $sformatf("ch%0d count after stop", ch));
      repeat (10) @(negedge pclk);
      apb_read(reg_addr(OFS_VAL, ch), got);
      check_reg(got, 32'(r / p), $sformatf("ch%0d count while stopped", ch));
   endtask

   task automatic interval_up(input int ch, input logic [15:0] intv);
      logic [31:0] got;
      apb_write(reg_addr(OFS_INTV, ch), 32'(intv));
      apb_write(reg_addr(OFS_CLK, ch), 32'h0);
      apb_write(reg_addr(OFS_CNTR, ch), 32'(1 << CC_INTV));
      for (int i = 0; i < 8; i++) begin
         apb_read(reg_addr(OFS_VAL, ch), got);
         if (got > 32'(intv)) begin
            errors++;
            $display("mismatch at %0t: counter %0d above interval %0d", $time, got, intv);
         end
      end
      apb_write(reg_addr(OFS_CNTR, ch), 32'((1 << CC_INTV) | (1 << CC_DIS)));
      apb_read(reg_addr(OFS_IRQ, ch), got);
      check_reg(got, 32'(1 << IRQ_INTV), "interval event, up count");
   endtask

   task automatic interval_down(input int ch, input logic [15:0] intv);
      logic [31:0] got;
      apb_write(reg_addr(OFS_INTV, ch), 32'(intv));
      apb_write(reg_addr(OFS_CLK, ch), 32'h0);
      apb_write(reg_addr(OFS_CNTR, ch), 32'((1 << CC_INTV) | (1 << CC_DEC)));
      repeat (2 * int'(intv) + 6) @(negedge pclk);   // Past one reload
      apb_write(reg_addr(OFS_CNTR, ch), 32'((1 << CC_INTV) | (1 << CC_DEC) | (1 << CC_DIS)));
      apb_read(reg_addr(OFS_IRQ, ch), got);
      check_reg(got, 32'(1 << IRQ_INTV), "interval event, down count");
   endtask

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------
   initial begin
      logic [31:0] got;
      lfsr    = 32'h7d1;
      errors  = 0;
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();
      repeat (RST_CYC) @(negedge pclk);
      arst_n = 1'b1;

      check_irq(interrupt, '0, "interrupts after reset");
      for (int i = 0; i < TBL_LEN; i++) begin
         if (tbl_wr[i]) apb_write(tbl_addr[i], tbl_wdata[i]);
         apb_read(tbl_addr[i], got);
         check_reg(got, tbl_exp[i] & tbl_mask[i], $sformatf("row %0d addr %h", i, tbl_addr[i]));
      end

      // Stop and clear every channel that random control may have started
      for (int c = 0; c < NUM_CH; c++) apb_write(reg_addr(OFS_CNTR, c), 32'(1 << CC_DIS));
      for (int c = 0; c < NUM_CH; c++) begin
         apb_write(reg_addr(OFS_IEN, c), 32'h0);
         apb_read(reg_addr(OFS_IRQ, c), got);
      end

      count_case(0, 5'b00011, 20);     // P = 4
      count_case(1, 5'b00000, 9);      // No prescale
      count_case(2, 5'b00101, 30);     // P = 8

      interval_up(0, 16'd5);
      interval_down(1, 16'd7);

      // Match events on ch2 with only M2 enabled
      apb_write(reg_addr(OFS_CLK, 2), 32'h0);
      apb_write(reg_addr(OFS_M1, 2), 32'd3);
      apb_write(reg_addr(OFS_M2, 2), 32'd6);
      apb_write(reg_addr(OFS_M3, 2), 32'd9);
      apb_write(reg_addr(OFS_IEN, 2), 32'(1 << IRQ_M2));
      apb_write(reg_addr(OFS_IEN, 0), 32'(1 << IRQ_OVF));
      apb_write(reg_addr(OFS_CNTR, 2), 32'(1 << CC_MATCH));
      repeat (12) @(negedge pclk);
      apb_write(reg_addr(OFS_CNTR, 2), 32'((1 << CC_MATCH) | (1 << CC_DIS)));
      repeat (3) @(negedge pclk);
      check_irq(interrupt, 3'b100, "interrupt lines after match");

      // Enable mask covering none of the latched bits
      apb_write(reg_addr(OFS_IEN, 2), 32'(1 << IRQ_OVF));
      repeat (2) @(negedge pclk);
      check_irq(interrupt, '0, "interrupt lines with match bits masked");
      apb_write(reg_addr(OFS_IEN, 2), 32'(1 << IRQ_M2));

      // Clear on read
      apb_read(reg_addr(OFS_IRQ, 2), got);
      check_reg(got, 32'((1 << IRQ_M1) | (1 << IRQ_M2) | (1 << IRQ_M3)), "ch2 match bits");
      apb_read(reg_addr(OFS_IRQ, 2), got);
      check_reg(got, 32'h0, "ch2 irq after clear");
      check_irq(interrupt, '0, "interrupt lines after clear");

      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_CYC * PERIOD);
      $display("watchdog expired after %0d cycles, errors so far: %0d", TIMEOUT_CYC, errors);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* ttc_lite.f */
hw/ttc_pkg.sv
hw/ttc_prescaler.sv
hw/ttc_count_fsm.sv
hw/ttc_counter.sv
hw/ttc_channel.sv
hw/ttc_apb_regs.sv
hw/ttc_lite.sv
tb/ttc_lite_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = ttc_lite_tb
FILELIST = ttc_lite.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
